//--- bench/cmd_seq_tb.sv
/*
 * testbench for the command sequencer: bus readback, random sequences
 * in all line codes, external start and starts while busy
 */
module cmd_seq_tb
    import cmd_seq_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ABUS     = 16;
    localparam int MEM_SIZE = 2048;
    localparam int RUNS     = 12;

    logic            CMD_CLK_IN;
    logic            RST_CMD_CLK;
    logic [ABUS-1:0] bus_add;
    cmd_byte_t       bus_data_in;
    logic            bus_wr;
    logic            bus_rd;
    logic            cmd_ext_start_flag;
    cmd_byte_t       bus_data_out;
    logic            cmd_data;
    logic            cmd_ready;
    logic            cmd_start_flag;
    logic            cmd_ext_start_enable;

    logic [31:0] rng = 32'hb2e11d16;
    int          cycles = 0;
    int          cycle_limit = 500;  // grows with each run
    cmd_byte_t   mem_img [32];
    logic        exp_level [$];      // expected cmd_data, one entry per cycle
    logic        exp_pulse [$];

    cmd_seq_top #(.ABUSWIDTH(ABUS), .CMD_MEM_SIZE(MEM_SIZE)) cmd_seq_top_i (.*);

    initial begin
        CMD_CLK_IN = 1'b0;
        forever #4 CMD_CLK_IN = !CMD_CLK_IN;
    end

    always @(posedge CMD_CLK_IN) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles, the run did not finish", cycles));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [31:0] rand_next();
        rng = rng * 32'd1664525 + 32'd1013904223;  // lcg
        return rng;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(rand_next() >> 8) % (hi - lo + 1);
    endfunction

    task automatic check_byte(input string name, input cmd_byte_t got, input cmd_byte_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input int idx, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s at cycle %0d: got 0x%h, expected 0x%h",
                                name, idx, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic tick();
        @(posedge CMD_CLK_IN);
        #1;
    endtask

    task automatic bus_write(input int addr, input cmd_byte_t data);
        bus_add     = ABUS'(addr);
        bus_data_in = data;
        bus_wr      = 1'b1;
        tick();
        bus_wr = 1'b0;
    endtask

    // little-endian field of several bytes
    task automatic write_field(input int addr, input int value, input int bytes);
        for (int i = 0; i < bytes; i++) begin
            bus_write(addr + i, cmd_byte_t'(value >> (8 * i)));
        end
    endtask

    task automatic read_expect(input int addr, input cmd_byte_t exp, input string name);
        bus_add = ABUS'(addr);
        bus_rd  = 1'b1;
        tick();
        bus_rd = 1'b0;
        check_byte(name, bus_data_out, exp);
    endtask

    task automatic read_finish(input logic exp);
        bus_add = ABUS'(REG_START);
        bus_rd  = 1'b1;
        tick();
        bus_rd = 1'b0;
        check_flag("finish flag", bus_data_out[0], exp);
    endtask

    task automatic readback_test();
        int        addr [8];
        cmd_byte_t data [8];
        cmd_byte_t regs [16];
        read_expect(REG_SOFT_RST, 8'd0, "version");
        for (int a = REG_CONF; a < MEM_BASE; a++) begin
            read_expect(a, (a == REG_REPEAT) ? 8'd1 : 8'd0, $sformatf("default %0d", a));
        end
        for (int a = REG_CONF; a < MEM_BASE; a++) begin
            regs[a] = cmd_byte_t'(rand_next() >> 24);
            bus_write(a, regs[a]);
        end
        for (int i = 0; i < 8; i++) begin
            addr[i] = MEM_BASE + i * 250 + rand_range(0, 249);  // spread, no overlap
            data[i] = cmd_byte_t'(rand_next() >> 24);
            bus_write(addr[i], data[i]);
        end
        for (int a = REG_CONF; a < MEM_BASE; a++) begin
            read_expect(a, regs[a], $sformatf("register %0d", a));
        end
        for (int i = 0; i < 8; i++) begin
            read_expect(addr[i], data[i], $sformatf("memory %0d", addr[i]));
        end
        read_expect(MEM_SIZE + rand_range(0, 1000), 8'd0, "unmapped read");
        bus_write(REG_SOFT_RST, 8'd0);
        for (int a = REG_CONF; a < MEM_BASE; a++) begin
            read_expect(a, (a == REG_REPEAT) ? 8'd1 : 8'd0, $sformatf("soft reset %0d", a));
        end
        for (int i = 0; i < 8; i++) begin
            read_expect(addr[i], data[i], "memory after soft reset");
        end
    endtask

    // bit k of the sequence, expanded into line levels
    task automatic push_bit(input int k, input int mode, input logic pulse);
        logic b;
        b = mem_img[k / 8][7 - k % 8];
        if (mode == int'(LINE_MAN_IEEE)) begin
            exp_level.push_back(!b);
            exp_level.push_back(b);
            exp_pulse.push_back(pulse);
            exp_pulse.push_back(1'b0);
        end else if (mode == int'(LINE_MAN_THOMAS)) begin
            exp_level.push_back(b);
            exp_level.push_back(!b);
            exp_pulse.push_back(pulse);
            exp_pulse.push_back(1'b0);
        end else begin
            exp_level.push_back(b);
            exp_pulse.push_back(pulse);
        end
    endtask

    task automatic seq_run(input int run);
        int   n;
        int   s;
        int   p;
        int   r;
        int   mid;
        int   mode;
        int   nbytes;
        int   dur;
        logic dis;
        logic ext;
        n      = rand_range(2, 120);
        s      = rand_range(0, n - 2);
        p      = rand_range(0, n - s - 2);
        r      = (run == 0) ? 1 : rand_range(0, 4);  // 0 means one pass
        mode   = run % 4;
        dis    = rand_range(0, 1) == 1;
        ext    = run >= 8;
        nbytes = (n + 7) / 8;
        mid    = n - p - 1;  // last bit of the middle section
        for (int i = 0; i < nbytes; i++) begin
            mem_img[i] = cmd_byte_t'(rand_next() >> 24);
        end
        exp_level.delete();
        exp_pulse.delete();
        for (int k = 0; k <= mid; k++) begin
            push_bit(k, mode, k == s && s > 0 && !dis);
        end
        for (int pass = 2; pass <= ((r == 0) ? 1 : r); pass++) begin
            for (int k = s; k <= mid; k++) begin
                push_bit(k, mode, k == s && !dis);
            end
        end
        for (int k = mid + 1; k < n; k++) begin
            push_bit(k, mode, 1'b0);
        end
        dur = exp_level.size();
        cycle_limit += 2 * dur + 20 + 2 * (nbytes + 20);

        bus_write(REG_CONF, {3'd0, dis, 1'b0, 2'(mode), 1'b0});
        write_field(REG_CMD_SIZE, n, 2);
        write_field(REG_REPEAT, r, 4);
        write_field(REG_START_REP, s, 2);
        write_field(REG_STOP_REP, p, 2);
        for (int i = 0; i < nbytes; i++) begin
            bus_write(MEM_BASE + i, mem_img[i]);
        end
        check_flag("cmd_ext_start_enable", cmd_ext_start_enable, 1'b0);
        if (ext) begin
            cmd_ext_start_flag = 1'b1;  // not enabled yet, must be ignored
            tick();
            cmd_ext_start_flag = 1'b0;
            repeat (3) begin
                tick();
                check_flag("cmd_ready", cmd_ready, 1'b1);
            end
            bus_write(REG_CONF, {3'd0, dis, 1'b0, 2'(mode), 1'b1});
            check_flag("cmd_ext_start_enable", cmd_ext_start_enable, 1'b1);
            cmd_ext_start_flag = 1'b1;
        end else begin
            bus_add = ABUS'(REG_START);
            bus_wr  = 1'b1;
        end

        for (int k = 1; k <= dur + 4; k++) begin
            tick();
            if (k == 1 || k == 5) begin
                bus_wr             = 1'b0;
                cmd_ext_start_flag = 1'b0;
            end
            if (k < 3 || k >= dur + 3) begin
                check_bit("cmd_data", k, cmd_data, 1'b0);
                check_bit("cmd_start_flag", k, cmd_start_flag, 1'b0);
            end else begin
                check_bit("cmd_data", k, cmd_data, exp_level[k - 3]);
                check_bit("cmd_start_flag", k, cmd_start_flag, exp_pulse[k - 3]);
            end
            check_flag("cmd_ready", cmd_ready, k == dur + 4);
            if (k == 1 && !ext) begin
                bus_add = ABUS'(REG_START);
                bus_rd  = 1'b1;
            end
            if (k == 2 && !ext) begin
                bus_rd = 1'b0;
                check_flag("finish flag", bus_data_out[0], 1'b0);  // cleared by the start
            end
            if (k == 4) begin
                bus_add            = ABUS'(REG_START);  // both starts while busy
                bus_wr             = 1'b1;
                cmd_ext_start_flag = 1'b1;
            end
        end
        read_finish(1'b1);
    endtask

    initial begin
        RST_CMD_CLK        = 1'b1;
        bus_add            = '0;
        bus_data_in        = '0;
        bus_wr             = 1'b0;
        bus_rd             = 1'b0;
        cmd_ext_start_flag = 1'b0;
        repeat (4) tick();
        RST_CMD_CLK = 1'b0;
        check_flag("cmd_ready", cmd_ready, 1'b1);
        check_bit("cmd_data", 0, cmd_data, 1'b0);
        readback_test();
        for (int run = 0; run < RUNS; run++) begin
            seq_run(run);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- hw/cmd_seq_ctrl.sv
/*
 * sequencer FSM with bit index and pass counters,
 * one-bit-ahead memory addressing and the current byte shift register
 */
module cmd_seq_ctrl
    import cmd_seq_pkg::*;
#(
    parameter int CMD_MEM_SIZE = 2048
) (
    input  logic                            CMD_CLK_IN,
    input  logic                            RST_CMD_CLK,
    input  cmd_seq_conf_t                   conf,
    input  logic                            seq_start,
    input  logic                            soft_rst,
    input  logic                            cmd_ext_start_flag,
    input  cmd_byte_t                       mem_rd_data,
    input  logic                            bit_adv,
    output logic [$clog2(CMD_MEM_SIZE)-1:0] mem_rd_addr,
    output cmd_bit_t                        bit_out,
    output logic                            busy
);

    localparam int AW = $clog2(CMD_MEM_SIZE);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_FETCH,
        SEQ_SEND
    } seq_state_t;

    seq_state_t state;
    cmd_len_t   cnt_nxt;    // index of the bit after the one on bit_out
    cmd_rep_t   pass;       // pass that cnt_nxt belongs to, from 1
    logic       nxt_done;   // cnt_nxt is past the last bit
    logic       cur_sec;
    cmd_byte_t  shreg;      // current bit at the msb

    cmd_len_t   mid_last;
    cmd_len_t   last_idx;
    cmd_len_t   after_idx;
    cmd_len_t   fetch_idx;
    cmd_rep_t   r_eff;
    cmd_rep_t   after_pass;
    logic       wrap;
    logic       after_done;
    logic       nxt_sec;
    logic       adv;
    logic       go;

    assign r_eff    = (conf.repeat_count == '0) ? cmd_rep_t'(1) : conf.repeat_count;
    assign mid_last = conf.cmd_size - conf.stop_repeat - 16'd1;  // end of middle section
    assign last_idx = conf.cmd_size - 16'd1;

    // successor of cnt_nxt in the stream
    assign wrap       = (cnt_nxt == mid_last) && (pass < r_eff);
    assign after_idx  = wrap ? conf.start_repeat : cnt_nxt + 16'd1;
    assign after_pass = wrap ? pass + 32'd1 : pass;
    assign after_done = !wrap && (cnt_nxt == last_idx);

    // section start: bit S in every pass, except pass 1 when S is 0
    assign nxt_sec = (cnt_nxt == conf.start_repeat) &&
                     (conf.start_repeat != '0 || pass != cmd_rep_t'(1));

    assign adv = (state == SEQ_FETCH) || (state == SEQ_SEND && bit_adv);
    assign go  = !busy && (seq_start || (cmd_ext_start_flag && conf.en_ext_start));

    // mem_rd_data must hold the byte of cnt_nxt at every advance edge.
    // when advancing this cycle the next load is the bit after cnt_nxt
    always_comb begin
        if (state == SEQ_IDLE || nxt_done) begin
            fetch_idx = '0;
        end else if (adv && !after_done) begin
            fetch_idx = after_idx;
        end else begin
            fetch_idx = cnt_nxt;
        end
    end

    assign mem_rd_addr = AW'(fetch_idx >> 3);

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_rst) begin
            state    <= SEQ_IDLE;
            busy     <= 1'b0;
            cnt_nxt  <= '0;
            pass     <= cmd_rep_t'(1);
            nxt_done <= 1'b0;
            cur_sec  <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (go) begin
                        state    <= SEQ_FETCH;
                        busy     <= 1'b1;
                        cnt_nxt  <= '0;
                        pass     <= cmd_rep_t'(1);
                        nxt_done <= 1'b0;
                    end else begin
                        busy <= 1'b0;  // one cycle after the last bit
                    end
                end
                SEQ_FETCH, SEQ_SEND: begin
                    if (adv) begin
                        if (nxt_done) begin
                            state <= SEQ_IDLE;
                        end else begin
                            state    <= SEQ_SEND;
                            cnt_nxt  <= after_idx;
                            pass     <= after_pass;
                            nxt_done <= after_done;
                            cur_sec  <= nxt_sec;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // reload on a byte boundary and after a jump back
    always_ff @(posedge CMD_CLK_IN) begin
        if (adv && !nxt_done) begin
            if (cnt_nxt[2:0] == 3'd0 || cnt_nxt == conf.start_repeat) begin
                shreg <= mem_rd_data << cnt_nxt[2:0];
            end else begin
                shreg <= {shreg[6:0], 1'b0};
            end
        end
    end

    assign bit_out.valid         = (state == SEQ_SEND);
    assign bit_out.data          = shreg[7];
    assign bit_out.section_start = cur_sec;

    // busy must cover every presented bit
    assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        !busy |-> !bit_out.valid)
        else $error("bit presented while sequencer idle");

endmodule

//--- hw/cmd_seq_encoder.sv
/*
 * line encoder: plain level or two-cycle manchester symbols,
 * bit pacing for the sequencer and the section start pulse
 */
module cmd_seq_encoder
    import cmd_seq_pkg::*;
(
    input  logic       CMD_CLK_IN,
    input  logic       RST_CMD_CLK,
    input  cmd_bit_t   bit_out,
    input  line_mode_t line_mode,
    input  logic       dis_cmd_pulse,
    output logic       bit_adv,
    output logic       cmd_data,
    output logic       cmd_start_flag
);

    logic man;    // two cycles per bit
    logic phase;  // 0 first half, 1 second half
    logic level;

    assign man = (line_mode == LINE_MAN_IEEE) || (line_mode == LINE_MAN_THOMAS);

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            phase <= 1'b0;
        end else if (bit_out.valid && man) begin
            phase <= !phase;
        end else begin
            phase <= 1'b0;
        end
    end

    assign bit_adv = man ? phase : 1'b1;  // last cycle of the bit period

    always_comb begin
        case (line_mode)
            LINE_MAN_IEEE:   level = phase ? bit_out.data : !bit_out.data;
            LINE_MAN_THOMAS: level = phase ? !bit_out.data : bit_out.data;
            default:         level = bit_out.data;  // nrz, both codes
        endcase
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            cmd_data       <= 1'b0;
            cmd_start_flag <= 1'b0;
        end else begin
            cmd_data       <= bit_out.valid && level;  // line idles low
            // first cycle of the section's first bit only
            cmd_start_flag <= bit_out.valid && bit_out.section_start &&
                              !phase && !dis_cmd_pulse;
        end
    end

    // sequencer must hold a bit for both halves of a manchester symbol
    assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        (bit_out.valid && man && !phase) |=> bit_out.valid)
        else $error("bit dropped in the middle of a manchester symbol");

endmodule

//--- hw/cmd_seq_pkg.sv
/*
 * command sequencer shared types: field widths, line codes,
 * configuration and bit strobe structs, bus register map
 */
package cmd_seq_pkg;

    typedef logic [7:0]  cmd_byte_t;  // bus data and memory byte
    typedef logic [15:0] cmd_len_t;   // bit count or bit index
    typedef logic [31:0] cmd_rep_t;   // repeat count

    // line code of the command output
    typedef enum logic [1:0] {
        LINE_NRZ        = 2'd0,
        LINE_NRZ_ALT    = 2'd1,  // same as plain level
        LINE_MAN_IEEE   = 2'd2,  // inverted bit first
        LINE_MAN_THOMAS = 2'd3   // bit first, then inverted
    } line_mode_t;

    // sequencer configuration, 84 bits
    typedef struct packed {
        logic       en_ext_start;
        logic       dis_cmd_pulse;
        line_mode_t line_mode;
        cmd_len_t   cmd_size;
        cmd_len_t   start_repeat;
        cmd_len_t   stop_repeat;
        cmd_rep_t   repeat_count;
    } cmd_seq_conf_t;

    // one bit handed from the sequencer to the encoder
    typedef struct packed {
        logic valid;
        logic data;
        logic section_start;  // first bit of a repeated section
    } cmd_bit_t;

    // byte addresses on the bus
    localparam int REG_SOFT_RST  = 0;
    localparam int REG_START     = 1;
    localparam int REG_CONF      = 2;
    localparam int REG_CMD_SIZE  = 3;   // 2 bytes
    localparam int REG_REPEAT    = 5;   // 4 bytes
    localparam int REG_START_REP = 9;   // 2 bytes
    localparam int REG_STOP_REP  = 11;  // 2 bytes
    localparam int MEM_BASE      = 16;

    // conf byte bit positions
    localparam int CONF_EN_EXT_START  = 0;
    localparam int CONF_LINE_MODE_LO  = 1;
    localparam int CONF_DIS_CMD_PULSE = 4;

endpackage

//--- hw/cmd_seq_regs.sv
/*
 * bus decode, register bytes and strobes, finish flag and ready,
 * command memory with a bus port and a registered sequencer read port
 */
module cmd_seq_regs
    import cmd_seq_pkg::*;
#(
    parameter int ABUSWIDTH    = 16,
    parameter int CMD_MEM_SIZE = 2048
) (
    input  logic                            CMD_CLK_IN,
    input  logic                            RST_CMD_CLK,
    input  logic [ABUSWIDTH-1:0]            bus_add,
    input  cmd_byte_t                       bus_data_in,
    input  logic                            bus_wr,
    input  logic                            bus_rd,
    input  logic [$clog2(CMD_MEM_SIZE)-1:0] mem_rd_addr,
    input  logic                            busy,
    output cmd_byte_t                       bus_data_out,
    output cmd_byte_t                       mem_rd_data,
    output cmd_seq_conf_t                   conf,
    output logic                            seq_start,
    output logic                            soft_rst,
    output logic                            cmd_ready
);

    localparam int AW        = $clog2(CMD_MEM_SIZE);
    localparam int MEM_DEPTH = CMD_MEM_SIZE - MEM_BASE;
    localparam cmd_byte_t VERSION = 8'd0;

    localparam logic [ABUSWIDTH-1:0] ADD_SOFT_RST = ABUSWIDTH'(REG_SOFT_RST);
    localparam logic [ABUSWIDTH-1:0] ADD_START    = ABUSWIDTH'(REG_START);
    localparam logic [ABUSWIDTH-1:0] ADD_CONF     = ABUSWIDTH'(REG_CONF);
    localparam logic [ABUSWIDTH-1:0] ADD_MEM      = ABUSWIDTH'(MEM_BASE);
    localparam logic [ABUSWIDTH-1:0] ADD_END      = ABUSWIDTH'(CMD_MEM_SIZE);

    cmd_byte_t        reg_q [REG_CONF:MEM_BASE-1];  // bytes 2 to 15
    cmd_byte_t        cmd_mem [MEM_DEPTH];
    logic [AW-1:0]    bus_mem_idx;
    logic             busy_q;
    logic             finish;

    assign soft_rst    = bus_wr && (bus_add == ADD_SOFT_RST);
    assign seq_start   = bus_wr && (bus_add == ADD_START);
    assign bus_mem_idx = AW'(bus_add - ADD_MEM);

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_rst) begin
            for (int i = REG_CONF; i < MEM_BASE; i++) begin
                reg_q[i] <= (i == REG_REPEAT) ? 8'd1 : 8'd0;  // one pass by default
            end
        end else if (bus_wr && bus_add >= ADD_CONF && bus_add < ADD_MEM) begin
            reg_q[bus_add[3:0]] <= bus_data_in;
        end
    end

    // little-endian fields
    assign conf.en_ext_start  = reg_q[REG_CONF][CONF_EN_EXT_START];
    assign conf.dis_cmd_pulse = reg_q[REG_CONF][CONF_DIS_CMD_PULSE];
    assign conf.line_mode     = line_mode_t'(reg_q[REG_CONF][CONF_LINE_MODE_LO +: 2]);
    assign conf.cmd_size      = {reg_q[REG_CMD_SIZE + 1], reg_q[REG_CMD_SIZE]};
    assign conf.start_repeat  = {reg_q[REG_START_REP + 1], reg_q[REG_START_REP]};
    assign conf.stop_repeat   = {reg_q[REG_STOP_REP + 1], reg_q[REG_STOP_REP]};
    assign conf.repeat_count  = {reg_q[REG_REPEAT + 3], reg_q[REG_REPEAT + 2],
                                 reg_q[REG_REPEAT + 1], reg_q[REG_REPEAT]};

    always_ff @(posedge CMD_CLK_IN) begin
        if (bus_wr && bus_add >= ADD_MEM && bus_add < ADD_END) begin
            cmd_mem[bus_mem_idx] <= bus_data_in;
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        mem_rd_data <= cmd_mem[mem_rd_addr];  // sequencer port
    end

    // bus read, value held until the next read
    always_ff @(posedge CMD_CLK_IN) begin
        if (bus_rd) begin
            if (bus_add == ADD_SOFT_RST) begin
                bus_data_out <= VERSION;
            end else if (bus_add == ADD_START) begin
                bus_data_out <= {7'd0, finish};
            end else if (bus_add < ADD_MEM) begin
                bus_data_out <= reg_q[bus_add[3:0]];
            end else if (bus_add < ADD_END) begin
                bus_data_out <= cmd_mem[bus_mem_idx];
            end else begin
                bus_data_out <= '0;
            end
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= busy;
        end
    end

    // nothing pending after reset
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_rst) begin
            finish <= 1'b1;
        end else if (seq_start) begin
            finish <= 1'b0;
        end else if (busy_q && !busy) begin
            finish <= 1'b1;  // run just ended
        end
    end

    // drops with busy, rises one cycle after busy falls
    assign cmd_ready = !(busy || busy_q);

endmodule

//--- hw/cmd_seq_top.sv
/*
 * command sequencer top level: register decode, sequencer
 * and line encoder between the byte bus and the command pins
 */
module cmd_seq_top
    import cmd_seq_pkg::*;
#(
    parameter int ABUSWIDTH    = 16,
    parameter int CMD_MEM_SIZE = 2048
) (
    input  logic                 CMD_CLK_IN,
    input  logic                 RST_CMD_CLK,
    input  logic [ABUSWIDTH-1:0] bus_add,
    input  cmd_byte_t            bus_data_in,
    input  logic                 bus_wr,
    input  logic                 bus_rd,
    input  logic                 cmd_ext_start_flag,
    output cmd_byte_t            bus_data_out,
    output logic                 cmd_data,
    output logic                 cmd_ready,
    output logic                 cmd_start_flag,
    output logic                 cmd_ext_start_enable
);

    cmd_seq_conf_t                   conf;
    cmd_bit_t                        bit_out;
    cmd_byte_t                       mem_rd_data;
    logic [$clog2(CMD_MEM_SIZE)-1:0] mem_rd_addr;
    logic                            seq_start;
    logic                            soft_rst;
    logic                            busy;
    logic                            bit_adv;

    assign cmd_ext_start_enable = conf.en_ext_start;

    cmd_seq_regs #(
        .ABUSWIDTH   (ABUSWIDTH),
        .CMD_MEM_SIZE(CMD_MEM_SIZE)
    ) cmd_seq_regs_i (
        .CMD_CLK_IN  (CMD_CLK_IN),
        .RST_CMD_CLK (RST_CMD_CLK),
        .bus_add     (bus_add),
        .bus_data_in (bus_data_in),
        .bus_wr      (bus_wr),
        .bus_rd      (bus_rd),
        .mem_rd_addr (mem_rd_addr),
        .busy        (busy),
        .bus_data_out(bus_data_out),
        .mem_rd_data (mem_rd_data),
        .conf        (conf),
        .seq_start   (seq_start),
        .soft_rst    (soft_rst),
        .cmd_ready   (cmd_ready)
    );

    cmd_seq_ctrl #(
        .CMD_MEM_SIZE(CMD_MEM_SIZE)
    ) cmd_seq_ctrl_i (
        .CMD_CLK_IN        (CMD_CLK_IN),
        .RST_CMD_CLK       (RST_CMD_CLK),
        .conf              (conf),
        .seq_start         (seq_start),
        .soft_rst          (soft_rst),
        .cmd_ext_start_flag(cmd_ext_start_flag),
        .mem_rd_data       (mem_rd_data),
        .bit_adv           (bit_adv),
        .mem_rd_addr       (mem_rd_addr),
        .bit_out           (bit_out),
        .busy              (busy)
    );

    cmd_seq_encoder cmd_seq_encoder_i (
        .CMD_CLK_IN    (CMD_CLK_IN),
        .RST_CMD_CLK   (RST_CMD_CLK),
        .bit_out       (bit_out),
        .line_mode     (conf.line_mode),
        .dis_cmd_pulse (conf.dis_cmd_pulse),
        .bit_adv       (bit_adv),
        .cmd_data      (cmd_data),
        .cmd_start_flag(cmd_start_flag)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build the command sequencer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cmd_seq_tb -f src.f -o cmd_seq_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/cmd_seq_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- src.f
hw/cmd_seq_pkg.sv
hw/cmd_seq_regs.sv
hw/cmd_seq_ctrl.sv
hw/cmd_seq_encoder.sv
hw/cmd_seq_top.sv
bench/cmd_seq_tb.sv
